//--- tb/tb_team_02_wrapper.sv
/*
 * Testbench for the team 02 GPIO streaming wrapper
 * Slave register traffic, a stalling memory on the master port, pin checks
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_team_02_wrapper;

    localparam int CLK_NS      = 20;
    localparam int N_TESTS     = 5;
    localparam int MAX_WORDS   = 16;
    localparam int CYC_PER_WRD = 6;                  // Arbitration, stall, NEXT
    localparam int WATCHDOG_NS = 21 * N_TESTS * MAX_WORDS * CYC_PER_WRD * CLK_NS; // ~200 us
    localparam logic [31:0] SLV_BASE = 32'h3000_0000;

    logic                        wb_clk = 1'b0;
    logic                        rst_n;
    logic                        wbs_stb, wbs_cyc, wbs_we, wbs_ack;
    logic [3:0]                  wbs_sel;
    logic [`TEAM02_DW-1:0]       wbs_adr, wbs_wdat, wbs_rdat;
    logic [`TEAM02_GPIO_W-1:0]   gpio_in, gpio_out, gpio_oeb;
    logic [2:0]                  irq;
    logic [`TEAM02_DW-1:0]       wbm_adr, wbm_wdat, wbm_rdat;
    logic [3:0]                  wbm_sel;
    logic                        wbm_we, wbm_stb, wbm_cyc, wbm_ack;

    logic [31:0] mem [0:255];                        // Memory behind the master port
    integer      seed = 32'h360c;
    int          n_writes, n_reads;
    logic [31:0] rd_word;                            // Last word handed to playback
    logic        rd_pending;

    always #(CLK_NS / 2) wb_clk = ~wb_clk;

    team_02_wrapper team_02_wrapper_i (
        .wb_clk_i(wb_clk),    .rst_n_i(rst_n),
        .wbs_stb_i(wbs_stb),  .wbs_cyc_i(wbs_cyc),   .wbs_we_i(wbs_we),
        .wbs_sel_i(wbs_sel),  .wbs_dat_i(wbs_wdat),  .wbs_adr_i(wbs_adr),
        .wbs_ack_o(wbs_ack),  .wbs_dat_o(wbs_rdat),
        .gpio_in_i(gpio_in),  .gpio_out_o(gpio_out), .gpio_oeb_o(gpio_oeb), .irq_o(irq),
        .wbm_adr_o(wbm_adr),  .wbm_dat_o(wbm_wdat),  .wbm_sel_o(wbm_sel),
        .wbm_we_o(wbm_we),    .wbm_stb_o(wbm_stb),   .wbm_cyc_o(wbm_cyc),
        .wbm_ack_i(wbm_ack),  .wbm_dat_i(wbm_rdat)
    );

    bind team_02_wrapper team_02_props team_02_props_i (
        .wb_clk_i(wb_clk_i),   .rst_n_i(rst_n_i),
        .wbm_adr_i(wbm_adr_o), .wbm_dat_i(wbm_dat_o), .wbm_sel_i(wbm_sel_o),
        .wbm_we_i(wbm_we_o),   .wbm_stb_i(wbm_stb_o), .wbm_cyc_i(wbm_cyc_o),
        .wbm_ack_i(wbm_ack_i), .wbs_ack_i(wbs_ack_o), .gpio_oeb_i(gpio_oeb_o)
    );

    task automatic stop_on_error(input string msg);
        $display("ERROR @ %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    // Usable pin order is gpio[35:5] then gpio[0]
    function automatic logic [`TEAM02_GPIO_W-1:0] pins_from_word(input logic [31:0] w);
        logic [`TEAM02_GPIO_W-1:0] p;
        p = '0;
        p[35:5] = w[31:1];
        p[0] = w[0];
        return p;
    endfunction

    function automatic logic [31:0] usable_bits(input logic [`TEAM02_GPIO_W-1:0] p);
        return {p[35:5], p[0]};
    endfunction

    function automatic logic [31:0] fill_word(input int a);
        return (32'(a) * 32'h9E37_79B9) ^ 32'h5A5A_0F0F;   // Whole word address mixed in
    endfunction

    // One classic slave cycle released on the negedge after ack
    task automatic slave_access(input logic we, input team_02_pkg::reg_sel_e off,
                                input logic [31:0] dat, output logic [31:0] rdat);
        @(negedge wb_clk);
        wbs_adr  = SLV_BASE + (32'(off) << 2);
        wbs_wdat = dat;
        wbs_sel  = 4'hf;
        wbs_we   = we;
        wbs_stb  = 1'b1;
        wbs_cyc  = 1'b1;
        @(negedge wb_clk);
        while (!wbs_ack) @(negedge wb_clk);
        rdat    = wbs_rdat;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic write_reg(input team_02_pkg::reg_sel_e off, input logic [31:0] dat);
        logic [31:0] unused;
        slave_access(1'b1, off, dat, unused);
    endtask

    task automatic check_reg(input team_02_pkg::reg_sel_e off, input logic [31:0] exp);
        logic [31:0] got;
        slave_access(1'b0, off, '0, got);
        assert (got == exp) else
            stop_on_error($sformatf("%s read %h, expected %h", off.name(), got, exp));
    endtask

    task automatic wait_done(input logic [1:0] mask);
        while ((irq[1:0] & mask) != mask) @(negedge wb_clk);   // Watchdog bounds this
    endtask

    task automatic clear_status();
        write_reg(team_02_pkg::REG_STATUS, 32'h3);
        assert (irq == 3'b000) else stop_on_error($sformatf("irq %b after W1C", irq));
    endtask

    task automatic check_block(input int base, input int len, input logic [31:0] exp);
        for (int i = 0; i < len; i++) begin
            assert (mem[base + i] == exp) else
                stop_on_error($sformatf("mem[%0d] = %h, expected %h", base + i,
                                        mem[base + i], exp));
        end
    endtask

    // Memory slave with 0 to 3 stall cycles
    initial begin : mem_model
        int         stall;
        logic [7:0] widx;
        wbm_ack    = 1'b0;
        wbm_rdat   = '0;
        rd_pending = 1'b0;
        forever begin
            @(negedge wb_clk);
            wbm_ack = 1'b0;
            if (rd_pending) begin                    // Word registered on the ack edge
                assert (usable_bits(gpio_out) == rd_word) else
                    stop_on_error($sformatf("gpio_out %h after read of %h",
                                            usable_bits(gpio_out), rd_word));
                rd_pending = 1'b0;
            end
            if (wbm_stb && wbm_cyc) begin
                stall = $unsigned($random(seed)) % 4;
                repeat (stall) @(negedge wb_clk);
                assert (wbm_sel == 4'hf) else     // Engines move whole words only
                    stop_on_error($sformatf("wbm_sel %h, expected f", wbm_sel));
                widx = wbm_adr[9:2];
                if (wbm_we) begin
                    mem[widx] = wbm_wdat;
                    n_writes++;
                end else begin
                    wbm_rdat   = mem[widx];
                    rd_word    = mem[widx];
                    rd_pending = 1'b1;
                    n_reads++;
                end
                wbm_ack = 1'b1;
            end
        end
    end

    always @(negedge wb_clk)
        assert (team_02_wrapper_i.team_02_props_i.violations == 0) else
            stop_on_error("bound protocol assertion failed");

    initial begin : watchdog
        #(WATCHDOG_NS);
        stop_on_error("watchdog expired before all tests finished");
    end

    initial begin : main
        logic [31:0] v_a, v_b, st;
        rst_n    = 1'b0;
        wbs_stb  = 1'b0;
        wbs_cyc  = 1'b0;
        wbs_we   = 1'b0;
        wbs_sel  = 4'h0;
        wbs_adr  = '0;
        wbs_wdat = '0;
        gpio_in  = '0;
        n_writes = 0;
        n_reads  = 0;
        for (int a = 0; a < 256; a++) mem[a] = fill_word(a);
        repeat (2) @(negedge wb_clk);
        rst_n = 1'b1;
        assert (gpio_oeb == '1 && irq == 3'b000 && usable_bits(gpio_out) == '0) else
            stop_on_error("outputs not at reset values");

        // Register access and pin enables
        write_reg(team_02_pkg::REG_CAP_ADDR, 32'h0000_0100);
        write_reg(team_02_pkg::REG_PLAY_ADDR, 32'h0000_0080);
        write_reg(team_02_pkg::REG_LEN, 32'd8);
        write_reg(team_02_pkg::REG_OEB, 32'hA5C3_0F1E);
        check_reg(team_02_pkg::REG_CAP_ADDR, 32'h0000_0100);
        check_reg(team_02_pkg::REG_PLAY_ADDR, 32'h0000_0080);
        check_reg(team_02_pkg::REG_LEN, 32'd8);
        check_reg(team_02_pkg::REG_OEB, 32'hA5C3_0F1E);
        assert (usable_bits(gpio_oeb) == 32'hA5C3_0F1E &&
                &{gpio_oeb[37:36], gpio_oeb[4:1]}) else
            stop_on_error($sformatf("gpio_oeb %h does not follow the mask", gpio_oeb));
        write_reg(team_02_pkg::REG_OEB, 32'h0);

        // Two capture runs into separate blocks
        v_a = $random(seed);
        gpio_in = pins_from_word(v_a);
        write_reg(team_02_pkg::REG_CTRL, 32'h1);
        wait_done(2'b01);
        check_block(64, 8, v_a);
        check_reg(team_02_pkg::REG_STATUS, 32'h1);   // Sticky bit set and engines idle
        clear_status();
        check_reg(team_02_pkg::REG_STATUS, 32'h0);
        v_b = ~v_a ^ $random(seed);
        gpio_in = pins_from_word(v_b);
        write_reg(team_02_pkg::REG_CAP_ADDR, 32'h0000_0180);
        write_reg(team_02_pkg::REG_CTRL, 32'h1);
        wait_done(2'b01);
        check_block(96, 8, v_b);
        check_block(64, 8, v_a);                     // First block untouched
        clear_status();

        // Playback of 16 preloaded words
        n_reads = 0;
        write_reg(team_02_pkg::REG_LEN, 32'd16);
        write_reg(team_02_pkg::REG_CTRL, 32'h2);
        wait_done(2'b10);
        assert (n_reads == 16 && gpio_out == pins_from_word(fill_word(47))) else
            stop_on_error($sformatf("playback: %0d reads, pins %h", n_reads, gpio_out));
        clear_status();

        // Both engines from one CTRL write
        v_a = $random(seed);
        gpio_in = pins_from_word(v_a);
        write_reg(team_02_pkg::REG_CAP_ADDR, 32'h0000_0200);
        write_reg(team_02_pkg::REG_PLAY_ADDR, 32'h0000_0280);
        write_reg(team_02_pkg::REG_LEN, 32'd12);
        n_writes = 0;
        n_reads  = 0;
        write_reg(team_02_pkg::REG_CTRL, 32'h3);
        wait_done(2'b11);
        check_block(128, 12, v_a);
        assert (n_writes == 12 && n_reads == 12 && usable_bits(gpio_out) == fill_word(171)) else
            stop_on_error($sformatf("overlap: %0d writes, %0d reads", n_writes, n_reads));
        clear_status();

        // LEN 0 finishes with no master cycle
        write_reg(team_02_pkg::REG_LEN, 32'd0);
        n_writes = 0;
        write_reg(team_02_pkg::REG_CTRL, 32'h1);
        wait_done(2'b01);
        assert (n_writes == 0 && n_reads == 12) else
            stop_on_error("LEN 0 produced master cycles");
        clear_status();

        // Second start while busy is dropped
        write_reg(team_02_pkg::REG_CAP_ADDR, 32'h0000_0300);
        write_reg(team_02_pkg::REG_LEN, 32'd8);
        write_reg(team_02_pkg::REG_CTRL, 32'h1);
        slave_access(1'b0, team_02_pkg::REG_STATUS, '0, st);
        assert (st[2]) else stop_on_error("capture not busy after start");
        write_reg(team_02_pkg::REG_CTRL, 32'h1);
        wait_done(2'b01);
        repeat (8) @(negedge wb_clk);
        assert (n_writes == 8) else
            stop_on_error($sformatf("%0d writes counted, expected 8", n_writes));
        check_reg(team_02_pkg::REG_STATUS, 32'h1);   // Idle again with no restart
        clear_status();

        if (team_02_wrapper_i.team_02_props_i.violations == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_error("bound protocol assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- tb/team_02_props.sv
/*
 * Team 02 bus and pin protocol checks
 * Bound onto the wrapper, every failed property bumps a violation count
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module team_02_props (
    input  wire                         wb_clk_i,
    input  wire                         rst_n_i,
    input  wire  [`TEAM02_DW-1:0]       wbm_adr_i,
    input  wire  [`TEAM02_DW-1:0]       wbm_dat_i,
    input  wire  [3:0]                  wbm_sel_i,
    input  wire                         wbm_we_i,
    input  wire                         wbm_stb_i,
    input  wire                         wbm_cyc_i,
    input  wire                         wbm_ack_i,
    input  wire                         wbs_ack_i,
    input  wire  [`TEAM02_GPIO_W-1:0]   gpio_oeb_i
);

    int unsigned violations = 0;                 // Read from the testbench top

    // Master request frozen while stalled
    req_stable: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (wbm_stb_i && !wbm_ack_i) |=>
            (wbm_stb_i && $stable({wbm_adr_i, wbm_dat_i, wbm_sel_i, wbm_we_i})))
    else begin
        $error("master request changed or dropped before ack");
        violations++;
    end

    stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wbm_stb_i |-> wbm_cyc_i)
    else begin
        $error("master stb high without cyc");
        violations++;
    end

    // Slave ack is a single pulse
    slv_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wbs_ack_i |=> !wbs_ack_i)
    else begin
        $error("slave ack held longer than one cycle");
        violations++;
    end

    fixed_pins_in: assert property (@(posedge wb_clk_i)
        &{gpio_oeb_i[37:36], gpio_oeb_i[4:1]})   // Pins 37:36 and 4:1 never drive
    else begin
        $error("fixed pin output enabled");
        violations++;
    end

endmodule

`default_nettype wire

//--- team_02_wrapper.f
+incdir+verilog
verilog/team_02_pkg.sv
verilog/wb_slave_regs.sv
verilog/gpio_capture.sv
verilog/gpio_playback.sv
verilog/wbm_arbiter.sv
verilog/team_02_wrapper.sv
tb/team_02_props.sv
tb/tb_team_02_wrapper.sv

//--- verilog/gpio_capture.sv
/*
 * GPIO capture engine
 * Samples the usable pins and writes LEN words to memory from the base address
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module gpio_capture (
    input  wire                         wb_clk_i,
    input  wire                         rst_n_i,
    input  wire                         start_i,
    input  wire  [`TEAM02_DW-1:0]       base_addr_i,
    input  wire  [`TEAM02_LEN_W-1:0]    len_i,
    input  wire  [`TEAM02_IO_W-1:0]     gpio_in_i,
    input  team_02_pkg::wb_rsp_t        rsp_i,
    output team_02_pkg::wb_req_t        req_o,
    output logic                        stb_o,
    output logic                        busy_o,
    output logic                        done_o
);

    team_02_pkg::eng_state_e    state_q;
    logic [`TEAM02_LEN_W-1:0]   idx_q;
    logic [`TEAM02_LEN_W-1:0]   len_q;                   // Latched at start
    logic [`TEAM02_DW-1:0]      base_q;
    logic [`TEAM02_IO_W-1:0]    data_q;
    logic                       sample;

    // Entering XFER from IDLE or from NEXT
    assign sample = ((state_q == team_02_pkg::ENG_IDLE) && start_i && (len_i != '0)) ||
                    ((state_q == team_02_pkg::ENG_NEXT) && (idx_q + 1'b1 != len_q));

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q <= team_02_pkg::ENG_IDLE;
            idx_q   <= '0;
            len_q   <= '0;
            base_q  <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                team_02_pkg::ENG_IDLE: if (start_i) begin
                    idx_q  <= '0;
                    len_q  <= len_i;
                    base_q <= base_addr_i;
                    if (len_i == '0) done_o <= 1'b1;     // Nothing to move
                    else state_q <= team_02_pkg::ENG_XFER;
                end
                team_02_pkg::ENG_XFER:
                    if (rsp_i.ack) state_q <= team_02_pkg::ENG_NEXT;
                team_02_pkg::ENG_NEXT: begin
                    if (idx_q + 1'b1 == len_q) begin    // Last word written
                        state_q <= team_02_pkg::ENG_IDLE;
                        done_o  <= 1'b1;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= team_02_pkg::ENG_XFER;
                    end
                end
                default: state_q <= team_02_pkg::ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (sample) data_q <= gpio_in_i;                 // Fresh pin sample per word
    end

    assign req_o.adr = base_q + (`TEAM02_DW'(idx_q) << 2);   // Word stride
    assign req_o.dat = data_q;
    assign req_o.sel = 4'hf;
    assign req_o.we  = 1'b1;
    assign stb_o     = (state_q == team_02_pkg::ENG_XFER);
    assign busy_o    = (state_q != team_02_pkg::ENG_IDLE);

endmodule

`default_nettype wire

//--- verilog/gpio_playback.sv
/*
 * GPIO playback engine
 * Reads LEN words from memory and drives each onto the usable output pins
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module gpio_playback (
    input  wire                         wb_clk_i,
    input  wire                         rst_n_i,
    input  wire                         start_i,
    input  wire  [`TEAM02_DW-1:0]       base_addr_i,
    input  wire  [`TEAM02_LEN_W-1:0]    len_i,
    input  team_02_pkg::wb_rsp_t        rsp_i,
    output team_02_pkg::wb_req_t        req_o,
    output logic                        stb_o,
    output logic                        busy_o,
    output logic                        done_o,
    output logic [`TEAM02_IO_W-1:0]     gpio_out_o
);

    team_02_pkg::eng_state_e    state_q;
    logic [`TEAM02_LEN_W-1:0]   idx_q;
    logic [`TEAM02_LEN_W-1:0]   len_q;
    logic [`TEAM02_DW-1:0]      base_q;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q    <= team_02_pkg::ENG_IDLE;
            idx_q      <= '0;
            len_q      <= '0;
            base_q     <= '0;
            done_o     <= 1'b0;
            gpio_out_o <= '0;                            // Pins low out of reset
        end else begin
            done_o <= 1'b0;
            case (state_q)
                team_02_pkg::ENG_IDLE: if (start_i) begin   // Ignored while busy
                    idx_q  <= '0;
                    len_q  <= len_i;
                    base_q <= base_addr_i;
                    if (len_i == '0) done_o <= 1'b1;
                    else state_q <= team_02_pkg::ENG_XFER;
                end
                team_02_pkg::ENG_XFER: if (rsp_i.ack) begin
                    gpio_out_o <= rsp_i.dat;             // Word to pins on ack edge
                    state_q    <= team_02_pkg::ENG_NEXT;
                end
                team_02_pkg::ENG_NEXT: begin
                    if (idx_q + 1'b1 == len_q) begin    // Last word stays on pins
                        state_q <= team_02_pkg::ENG_IDLE;
                        done_o  <= 1'b1;
                    end else begin
                        idx_q   <= idx_q + 1'b1;
                        state_q <= team_02_pkg::ENG_XFER;
                    end
                end
                default: state_q <= team_02_pkg::ENG_IDLE;
            endcase
        end
    end

    assign req_o.adr = base_q + (`TEAM02_DW'(idx_q) << 2);
    assign req_o.dat = '0;                               // Reads only
    assign req_o.sel = 4'hf;
    assign req_o.we  = 1'b0;
    assign stb_o     = (state_q == team_02_pkg::ENG_XFER);
    assign busy_o    = (state_q != team_02_pkg::ENG_IDLE);

endmodule

`default_nettype wire

//--- verilog/team_02_consts.svh
/*
 * Team 02 GPIO streaming constants
 * Bus and length widths, register decode width and usable pin map
 */
`ifndef TEAM_02_CONSTS_SVH
`define TEAM_02_CONSTS_SVH

`define TEAM02_DW       32  // Wishbone data and address width
`define TEAM02_LEN_W    16  // Transfer length in words
`define TEAM02_GPIO_W   38  // Harness pin count
`define TEAM02_IO_W     32  // Usable pins, gpio[35:5] plus gpio[0]

// Register word offset field, adr[4:2]
`define TEAM02_REG_AW   3

// Upper usable pin span, gpio[0] is appended below it
`define TEAM02_PIN_HI   35
`define TEAM02_PIN_LO   5

`endif

//--- verilog/team_02_pkg.sv
/*
 * Team 02 shared types
 * Wishbone request and response structs, engine and arbiter states, register map
 */
`include "team_02_consts.svh"
`default_nettype none

package team_02_pkg;

    typedef struct packed {
        logic [`TEAM02_DW-1:0]   adr;
        logic [`TEAM02_DW-1:0]   dat;
        logic [`TEAM02_DW/8-1:0] sel;
        logic                    we;
    } wb_req_t;                                 // 69 bits

    typedef struct packed {
        logic                  ack;
        logic [`TEAM02_DW-1:0] dat;
    } wb_rsp_t;                                 // 33 bits

    typedef enum logic [1:0] {
        ENG_IDLE = 2'd0,                        // Nothing in flight
        ENG_XFER = 2'd1,                        // Request outstanding
        ENG_NEXT = 2'd2                         // Bump index or finish
    } eng_state_e;

    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_CAP  = 2'd1,
        OWN_PLAY = 2'd2
    } arb_owner_e;

    // Slave register word offsets
    typedef enum logic [`TEAM02_REG_AW-1:0] {
        REG_CTRL      = 3'd0,
        REG_STATUS    = 3'd1,
        REG_CAP_ADDR  = 3'd2,
        REG_PLAY_ADDR = 3'd3,
        REG_LEN       = 3'd4,
        REG_OEB       = 3'd5
    } reg_sel_e;

endpackage

`default_nettype wire

//--- verilog/team_02_wrapper.sv
/*
 * Team 02 user area top
 * Harness Wishbone and GPIO ports onto registers, engines and master arbiter
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module team_02_wrapper (
    input  wire                         wb_clk_i,
    input  wire                         rst_n_i,
    // Wishbone slave
    input  wire                         wbs_stb_i,
    input  wire                         wbs_cyc_i,
    input  wire                         wbs_we_i,
    input  wire  [3:0]                  wbs_sel_i,
    input  wire  [`TEAM02_DW-1:0]       wbs_dat_i,
    input  wire  [`TEAM02_DW-1:0]       wbs_adr_i,
    output wire                         wbs_ack_o,
    output wire  [`TEAM02_DW-1:0]       wbs_dat_o,
    // GPIO
    input  wire  [`TEAM02_GPIO_W-1:0]   gpio_in_i,
    output wire  [`TEAM02_GPIO_W-1:0]   gpio_out_o,
    output wire  [`TEAM02_GPIO_W-1:0]   gpio_oeb_o,     // Active low
    output wire  [2:0]                  irq_o,
    // Wishbone master
    output wire  [`TEAM02_DW-1:0]       wbm_adr_o,
    output wire  [`TEAM02_DW-1:0]       wbm_dat_o,
    output wire  [3:0]                  wbm_sel_o,
    output wire                         wbm_we_o,
    output wire                         wbm_stb_o,
    output wire                         wbm_cyc_o,
    input  wire                         wbm_ack_i,
    input  wire  [`TEAM02_DW-1:0]       wbm_dat_i
);

    team_02_pkg::wb_req_t       wbs_req, wbm_req, cap_req, play_req;
    team_02_pkg::wb_rsp_t       wbs_rsp, wbm_rsp, cap_rsp, play_rsp;
    logic                       cap_start, play_start, cap_stb, play_stb;
    logic                       cap_busy, play_busy, cap_done, play_done;
    logic [`TEAM02_DW-1:0]      cap_addr, play_addr;
    logic [`TEAM02_LEN_W-1:0]   len;
    logic [`TEAM02_IO_W-1:0]    oeb_mask, io_in, io_out;
    logic [1:0]                 irq_done;

    assign wbs_req   = '{adr: wbs_adr_i, dat: wbs_dat_i, sel: wbs_sel_i, we: wbs_we_i};
    assign wbs_ack_o = wbs_rsp.ack;
    assign wbs_dat_o = wbs_rsp.dat;

    assign wbm_rsp   = '{ack: wbm_ack_i, dat: wbm_dat_i};
    assign wbm_adr_o = wbm_req.adr;
    assign wbm_dat_o = wbm_req.dat;
    assign wbm_sel_o = wbm_req.sel;
    assign wbm_we_o  = wbm_req.we;

    // Usable pins, gpio[35:5] then gpio[0]
    assign io_in = {gpio_in_i[`TEAM02_PIN_HI:`TEAM02_PIN_LO], gpio_in_i[0]};
    assign {gpio_out_o[`TEAM02_PIN_HI:`TEAM02_PIN_LO], gpio_out_o[0]} = io_out;
    assign {gpio_oeb_o[`TEAM02_PIN_HI:`TEAM02_PIN_LO], gpio_oeb_o[0]} = oeb_mask;
    assign {gpio_oeb_o[37:36], gpio_oeb_o[4:1]} = '1;   // Fixed inputs
    assign {gpio_out_o[37:36], gpio_out_o[4:1]} = '0;

    assign irq_o = {1'b0, irq_done};                     // irq[2] unused

    wb_slave_regs wb_slave_regs_i (
        .wb_clk_i(wb_clk_i),   .rst_n_i(rst_n_i),
        .wbs_req_i(wbs_req),   .wbs_stb_i(wbs_stb_i),  .wbs_cyc_i(wbs_cyc_i),
        .cap_busy_i(cap_busy), .play_busy_i(play_busy),
        .cap_done_i(cap_done), .play_done_i(play_done),
        .wbs_rsp_o(wbs_rsp),   .cap_start_o(cap_start), .play_start_o(play_start),
        .cap_addr_o(cap_addr), .play_addr_o(play_addr), .len_o(len),
        .oeb_mask_o(oeb_mask), .irq_o(irq_done)
    );

    gpio_capture gpio_capture_i (
        .wb_clk_i(wb_clk_i),   .rst_n_i(rst_n_i),     .start_i(cap_start),
        .base_addr_i(cap_addr), .len_i(len),          .gpio_in_i(io_in),
        .rsp_i(cap_rsp),       .req_o(cap_req),       .stb_o(cap_stb),
        .busy_o(cap_busy),     .done_o(cap_done)
    );

    gpio_playback gpio_playback_i (
        .wb_clk_i(wb_clk_i),   .rst_n_i(rst_n_i),     .start_i(play_start),
        .base_addr_i(play_addr), .len_i(len),         .rsp_i(play_rsp),
        .req_o(play_req),      .stb_o(play_stb),      .busy_o(play_busy),
        .done_o(play_done),    .gpio_out_o(io_out)
    );

    wbm_arbiter wbm_arbiter_i (
        .wb_clk_i(wb_clk_i),   .rst_n_i(rst_n_i),
        .cap_req_i(cap_req),   .cap_stb_i(cap_stb),
        .play_req_i(play_req), .play_stb_i(play_stb),
        .wbm_rsp_i(wbm_rsp),   .cap_rsp_o(cap_rsp),   .play_rsp_o(play_rsp),
        .wbm_req_o(wbm_req),   .wbm_stb_o(wbm_stb_o), .wbm_cyc_o(wbm_cyc_o)
    );

endmodule

`default_nettype wire

//--- verilog/wb_slave_regs.sv
/*
 * Wishbone slave register block
 * Control strobes, sticky done status, transfer setup and pin output enables
 */
`include "team_02_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module wb_slave_regs (
    input  wire                          wb_clk_i,
    input  wire                          rst_n_i,
    input  team_02_pkg::wb_req_t         wbs_req_i,
    input  wire                          wbs_stb_i,
    input  wire                          wbs_cyc_i,
    input  wire                          cap_busy_i,
    input  wire                          play_busy_i,
    input  wire                          cap_done_i,
    input  wire                          play_done_i,
    output team_02_pkg::wb_rsp_t         wbs_rsp_o,
    output logic                         cap_start_o,
    output logic                         play_start_o,
    output logic [`TEAM02_DW-1:0]        cap_addr_o,
    output logic [`TEAM02_DW-1:0]        play_addr_o,
    output logic [`TEAM02_LEN_W-1:0]     len_o,
    output logic [`TEAM02_IO_W-1:0]      oeb_mask_o,
    output logic [1:0]                   irq_o
);

    logic                    ack_q;
    logic [`TEAM02_DW-1:0]   rdata_q;
    logic                    access;
    logic                    wr_en;
    logic [`TEAM02_DW-1:0]   wdat;
    logic [3:0]              wsel;
    logic [`TEAM02_DW-1:0]   len_merged;
    logic [1:0]              done_set;
    team_02_pkg::reg_sel_e   sel_w;

    // Byte-lane write merge
    function automatic logic [`TEAM02_DW-1:0] merge(
        input logic [`TEAM02_DW-1:0] old_v,
        input logic [`TEAM02_DW-1:0] new_v,
        input logic [3:0]            be
    );
        logic [`TEAM02_DW-1:0] m;
        m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_v & ~m) | (new_v & m);
    endfunction

    assign access   = wbs_stb_i & wbs_cyc_i & ~ack_q;    // New cycle, not yet acked
    assign wr_en    = access & wbs_req_i.we;
    assign wdat     = wbs_req_i.dat;
    assign wsel     = wbs_req_i.sel;
    assign sel_w    = team_02_pkg::reg_sel_e'(wbs_req_i.adr[2 +: `TEAM02_REG_AW]);
    assign done_set = {play_done_i, cap_done_i};
    assign len_merged = merge({{(`TEAM02_DW-`TEAM02_LEN_W){1'b0}}, len_o}, wdat, wsel);

    assign wbs_rsp_o.ack = ack_q;
    assign wbs_rsp_o.dat = rdata_q;                      // Valid with ack

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            ack_q        <= 1'b0;
            cap_start_o  <= 1'b0;
            play_start_o <= 1'b0;
            cap_addr_o   <= '0;
            play_addr_o  <= '0;
            len_o        <= '0;
            oeb_mask_o   <= '1;                          // All pins input
            irq_o        <= 2'b00;
        end else begin
            ack_q        <= access;                      // One cycle later
            cap_start_o  <= 1'b0;                        // Pulses by default
            play_start_o <= 1'b0;
            irq_o        <= irq_o | done_set;            // Sticky set wins
            if (wr_en) begin
                case (sel_w)
                    team_02_pkg::REG_CTRL: begin
                        cap_start_o  <= wdat[0] & wsel[0];   // Lands with ack
                        play_start_o <= wdat[1] & wsel[0];
                    end
                    team_02_pkg::REG_STATUS:
                        irq_o <= (irq_o & ~(wdat[1:0] & {2{wsel[0]}})) | done_set; // W1C
                    team_02_pkg::REG_CAP_ADDR:  cap_addr_o  <= merge(cap_addr_o, wdat, wsel);
                    team_02_pkg::REG_PLAY_ADDR: play_addr_o <= merge(play_addr_o, wdat, wsel);
                    team_02_pkg::REG_LEN:       len_o <= len_merged[`TEAM02_LEN_W-1:0];
                    team_02_pkg::REG_OEB:       oeb_mask_o  <= merge(oeb_mask_o, wdat, wsel);
                    default: ;                           // Unmapped offset
                endcase
            end
        end
    end

    // Read mux, captured on the access edge
    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            case (sel_w)
                team_02_pkg::REG_STATUS:
                    rdata_q <= {28'b0, play_busy_i, cap_busy_i, irq_o};
                team_02_pkg::REG_CAP_ADDR:  rdata_q <= cap_addr_o;
                team_02_pkg::REG_PLAY_ADDR: rdata_q <= play_addr_o;
                team_02_pkg::REG_LEN:
                    rdata_q <= {{(`TEAM02_DW-`TEAM02_LEN_W){1'b0}}, len_o};
                team_02_pkg::REG_OEB:       rdata_q <= oeb_mask_o;
                default:                    rdata_q <= '0;   // CTRL reads zero
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/wbm_arbiter.sv
/*
 * Wishbone master arbiter
 * Round-robin share of one master port between capture and playback
 */
`timescale 1ns/1ps
`default_nettype none

module wbm_arbiter (
    input  wire                     wb_clk_i,
    input  wire                     rst_n_i,
    input  team_02_pkg::wb_req_t    cap_req_i,
    input  wire                     cap_stb_i,
    input  team_02_pkg::wb_req_t    play_req_i,
    input  wire                     play_stb_i,
    input  team_02_pkg::wb_rsp_t    wbm_rsp_i,
    output team_02_pkg::wb_rsp_t    cap_rsp_o,
    output team_02_pkg::wb_rsp_t    play_rsp_o,
    output team_02_pkg::wb_req_t    wbm_req_o,
    output logic                    wbm_stb_o,
    output logic                    wbm_cyc_o
);

    team_02_pkg::arb_owner_e owner_q;
    logic                    last_play_q;                // Last grant went to playback
    logic                    own_cap;
    logic                    own_play;

    assign own_cap  = (owner_q == team_02_pkg::OWN_CAP);
    assign own_play = (owner_q == team_02_pkg::OWN_PLAY);

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            owner_q     <= team_02_pkg::OWN_NONE;
            last_play_q <= 1'b0;
        end else begin
            case (owner_q)
                team_02_pkg::OWN_NONE: begin
                    if (cap_stb_i && (!play_stb_i || last_play_q)) begin
                        owner_q     <= team_02_pkg::OWN_CAP;
                        last_play_q <= 1'b0;
                    end else if (play_stb_i) begin
                        owner_q     <= team_02_pkg::OWN_PLAY;
                        last_play_q <= 1'b1;
                    end
                end
                default:
                    if (wbm_rsp_i.ack) owner_q <= team_02_pkg::OWN_NONE;  // Release on ack
            endcase
        end
    end

    assign wbm_req_o = own_play ? play_req_i : cap_req_i;
    assign wbm_stb_o = (own_cap & cap_stb_i) | (own_play & play_stb_i);
    assign wbm_cyc_o = wbm_stb_o;                        // Single classic cycles

    // Response steered to the owner only
    assign cap_rsp_o.ack  = wbm_rsp_i.ack & own_cap;
    assign cap_rsp_o.dat  = own_cap ? wbm_rsp_i.dat : '0;
    assign play_rsp_o.ack = wbm_rsp_i.ack & own_play;
    assign play_rsp_o.dat = own_play ? wbm_rsp_i.dat : '0;

endmodule

`default_nettype wire
